/* src/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

    // Datapath widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // Fixed instruction size, no compressed support
    localparam logic [XLEN-1:0] PC_STEP = 32'd4;

    // RV32I base opcodes
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

    // Load sizes, straight from funct3
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // Store sizes
    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    // Source of the register file write value
    typedef enum logic [1:0] {
        WB_NONE   = 2'b00,
        WB_PC4    = 2'b01,
        WB_RESULT = 2'b10,
        WB_MEM    = 2'b11
    } wb_sel_t;

    // Data memory geometry
    localparam int DMEM_WORDS  = 256;
    localparam int DMEM_ADDR_W = 8;

endpackage

`default_nettype wire

/* src/mem_access_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_access_unit (
    input  wire                                 clk,
    input  wire                                 reset_i,
    // Executed instruction from the upstream stage
    input  wire                                 in_valid_i,
    input  wire  [rv_core_pkg::XLEN-1:0]        in_pc_i,
    input  wire  [rv_core_pkg::XLEN-1:0]        in_inst_i,
    input  wire  [rv_core_pkg::XLEN-1:0]        in_result_i,
    input  wire  [rv_core_pkg::XLEN-1:0]        in_store_data_i,
    output logic                                in_ready_o,
    // APB requester side
    output logic                                psel_o,
    output logic                                penable_o,
    output logic                                pwrite_o,
    output logic [rv_core_pkg::XLEN-1:0]        paddr_o,
    output logic [rv_core_pkg::XLEN-1:0]        pwdata_o,
    output logic [rv_core_pkg::XLEN/8-1:0]      pstrb_o,
    input  wire  [rv_core_pkg::XLEN-1:0]        prdata_i,
    input  wire                                 pready_i,
    // Towards the writeback stage
    output logic                                mem_valid_o,
    output logic [rv_core_pkg::XLEN-1:0]        mem_pc_o,
    output logic [rv_core_pkg::XLEN-1:0]        mem_inst_o,
    output logic [rv_core_pkg::XLEN-1:0]        mem_result_o,
    output logic [rv_core_pkg::XLEN-1:0]        mem_load_data_o
);

    import rv_core_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS,
        ST_DONE
    } state_t;

    state_t          state_q;
    state_t          state_d;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] inst_q;
    logic [XLEN-1:0] result_q;
    logic [XLEN-1:0] store_data_q;
    logic [XLEN-1:0] rdata_q;
    logic [XLEN-1:0] load_shift;
    logic            accept;
    logic            in_is_mem;
    logic            xfer_done;
    logic [1:0]      byte_off;
    logic [2:0]      funct3;

    // Idle and done both take a new instruction
    assign in_ready_o = (state_q == ST_IDLE) || (state_q == ST_DONE);
    assign accept     = in_valid_i && in_ready_o;
    assign in_is_mem  = (in_inst_i[6:0] == OPCODE_LOAD) || (in_inst_i[6:0] == OPCODE_STORE);
    assign xfer_done  = (state_q == ST_ACCESS) && pready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE, ST_DONE: begin
                if (accept && in_is_mem) begin
                    state_d = ST_SETUP;
                end else begin
                    state_d = ST_IDLE;
                end
            end
            ST_SETUP: begin
                state_d = ST_ACCESS;
            end
            ST_ACCESS: begin
                if (pready_i) begin
                    state_d = ST_DONE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q     <= ST_IDLE;
            mem_valid_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            // One pulse per instruction, ALU ops skip the bus
            mem_valid_o <= (accept && !in_is_mem) || xfer_done;
        end
    end

    // Instruction held until the next one is taken
    always_ff @(posedge clk) begin
        if (accept) begin
            pc_q         <= in_pc_i;
            inst_q       <= in_inst_i;
            result_q     <= in_result_i;
            store_data_q <= in_store_data_i;
        end
        if (xfer_done) begin
            rdata_q <= prdata_i;
        end
    end

    assign byte_off = result_q[1:0];
    assign funct3   = inst_q[14:12];

    // APB request, word aligned
    assign psel_o    = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
    assign penable_o = (state_q == ST_ACCESS);
    assign pwrite_o  = (inst_q[6:0] == OPCODE_STORE);
    assign paddr_o   = {result_q[XLEN-1:2], 2'b00};

    // Store data moved onto its byte lanes
    always_comb begin
        pwdata_o = store_data_q << {byte_off, 3'b000};
        case (funct3)
            F3_SB:   pstrb_o = 4'b0001 << byte_off;
            F3_SH:   pstrb_o = 4'b0011 << byte_off;
            F3_SW:   pstrb_o = 4'b1111;
            default: pstrb_o = 4'b1111;
        endcase
    end

    // Load data brought down to bit 0, then extended
    assign load_shift = rdata_q >> {byte_off, 3'b000};

    always_comb begin
        case (funct3)
            F3_LB:   mem_load_data_o = {{(XLEN-8){load_shift[7]}}, load_shift[7:0]};
            F3_LH:   mem_load_data_o = {{(XLEN-16){load_shift[15]}}, load_shift[15:0]};
            F3_LW:   mem_load_data_o = load_shift;
            F3_LBU:  mem_load_data_o = {{(XLEN-8){1'b0}}, load_shift[7:0]};
            F3_LHU:  mem_load_data_o = {{(XLEN-16){1'b0}}, load_shift[15:0]};
            default: mem_load_data_o = load_shift;
        endcase
    end

    assign mem_pc_o     = pc_q;
    assign mem_inst_o   = inst_q;
    assign mem_result_o = result_q;

endmodule

`default_nettype wire

/* src/apb_data_mem.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_data_mem (
    input  wire                                 clk,
    input  wire                                 reset_i,
    // APB completer side
    input  wire                                 psel_i,
    input  wire                                 penable_i,
    input  wire                                 pwrite_i,
    input  wire  [rv_core_pkg::XLEN-1:0]        paddr_i,
    input  wire  [rv_core_pkg::XLEN-1:0]        pwdata_i,
    input  wire  [rv_core_pkg::XLEN/8-1:0]      pstrb_i,
    output logic [rv_core_pkg::XLEN-1:0]        prdata_o,
    output logic                                pready_o
);

    import rv_core_pkg::*;

    logic [XLEN-1:0]        mem_q [DMEM_WORDS];
    logic                   wait_q;
    logic                   access;
    logic [DMEM_ADDR_W-1:0] word_idx;

    assign access = psel_i && penable_i;

    // Upper address bits dropped, so the index wraps
    assign word_idx = paddr_i[DMEM_ADDR_W+1:2];

    // Set in the first access cycle, ready in the second
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wait_q <= 1'b0;
        end else if (access) begin
            wait_q <= !wait_q;
        end else begin
            wait_q <= 1'b0;
        end
    end

    assign pready_o = access && wait_q;

    // Read data fetched during the wait state
    always_ff @(posedge clk) begin
        if (access && !wait_q) begin
            prdata_o <= mem_q[word_idx];
        end
    end

    // Only strobed lanes are written
    always_ff @(posedge clk) begin
        if (pready_o && pwrite_i) begin
            for (int b = 0; b < XLEN/8; b++) begin
                if (pstrb_i[b]) begin
                    mem_q[word_idx][8*b +: 8] <= pwdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/write_back_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module write_back_unit (
    input  wire                                 clk,
    input  wire                                 reset_i,
    // Result of the memory stage
    input  wire                                 mem_valid_i,
    input  wire  [rv_core_pkg::XLEN-1:0]        mem_pc_i,
    input  wire  [rv_core_pkg::XLEN-1:0]        mem_inst_i,
    input  wire  [rv_core_pkg::XLEN-1:0]        mem_result_i,
    input  wire  [rv_core_pkg::XLEN-1:0]        mem_load_data_i,
    // Register file write port
    output logic                                rf_we_o,
    output logic [rv_core_pkg::REG_ADDR_W-1:0]  rf_waddr_o,
    output logic [rv_core_pkg::XLEN-1:0]        rf_wdata_o,
    // Retirement
    output logic                                wb_valid_o,
    output logic [rv_core_pkg::XLEN-1:0]        wb_pc_o
);

    import rv_core_pkg::*;

    logic            valid_q;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] inst_q;
    logic [XLEN-1:0] result_q;
    logic [XLEN-1:0] load_q;
    logic [XLEN-1:0] pc_plus4;
    logic [6:0]      opcode;
    wb_sel_t         wb_sel;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mem_valid_i;
        end
    end

    // Pipeline register, loaded only with a live instruction
    always_ff @(posedge clk) begin
        if (mem_valid_i) begin
            pc_q     <= mem_pc_i;
            inst_q   <= mem_inst_i;
            result_q <= mem_result_i;
            load_q   <= mem_load_data_i;
        end
    end

    assign opcode   = inst_q[6:0];
    assign pc_plus4 = pc_q + PC_STEP;

    // Write value source per opcode
    always_comb begin
        case (opcode)
            OPCODE_JAL:    wb_sel = WB_PC4;
            OPCODE_JALR:   wb_sel = WB_PC4;
            OPCODE_LOAD:   wb_sel = WB_MEM;
            OPCODE_LUI:    wb_sel = WB_RESULT;
            OPCODE_AUIPC:  wb_sel = WB_RESULT;
            OPCODE_OP:     wb_sel = WB_RESULT;
            OPCODE_OP_IMM: wb_sel = WB_RESULT;
            OPCODE_BRANCH: wb_sel = WB_NONE;
            OPCODE_STORE:  wb_sel = WB_NONE;
            OPCODE_SYSTEM: wb_sel = WB_NONE;
            default:       wb_sel = WB_NONE;
        endcase
    end

    always_comb begin
        case (wb_sel)
            WB_PC4:    rf_wdata_o = pc_plus4;
            WB_RESULT: rf_wdata_o = result_q;
            WB_MEM:    rf_wdata_o = load_q;
            default:   rf_wdata_o = '0;
        endcase
    end

    assign rf_waddr_o = inst_q[11:7];

    // Writes to x0 are dropped here as well
    assign rf_we_o = valid_q && (wb_sel != WB_NONE) && (rf_waddr_o != '0);

    assign wb_valid_o = valid_q;
    assign wb_pc_o    = pc_q;

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  wire                                 clk,
    input  wire                                 reset_i,
    // Write port from writeback
    input  wire                                 we_i,
    input  wire  [rv_core_pkg::REG_ADDR_W-1:0]  waddr_i,
    input  wire  [rv_core_pkg::XLEN-1:0]        wdata_i,
    // Read port for decode
    input  wire  [rv_core_pkg::REG_ADDR_W-1:0]  raddr_i,
    output logic [rv_core_pkg::XLEN-1:0]        rdata_o
);

    import rv_core_pkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs_q [1:2**REG_ADDR_W-1];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int r = 1; r < 2**REG_ADDR_W; r++) begin
                regs_q[r] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Combinational read, no bypass of a write in the same cycle
    assign rdata_o = (raddr_i == '0) ? '0 : regs_q[raddr_i];

endmodule

`default_nettype wire

/* src/lsu_wb_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lsu_wb_top (
    input  wire                                 clk,
    input  wire                                 reset_i,
    // Executed instruction in
    input  wire                                 in_valid_i,
    input  wire  [rv_core_pkg::XLEN-1:0]        in_pc_i,
    input  wire  [rv_core_pkg::XLEN-1:0]        in_inst_i,
    input  wire  [rv_core_pkg::XLEN-1:0]        in_result_i,
    input  wire  [rv_core_pkg::XLEN-1:0]        in_store_data_i,
    output logic                                in_ready_o,
    // Decode read port
    input  wire  [rv_core_pkg::REG_ADDR_W-1:0]  rs_addr_i,
    output logic [rv_core_pkg::XLEN-1:0]        rs_data_o,
    // Retire report
    output logic                                wb_valid_o,
    output logic [rv_core_pkg::XLEN-1:0]        wb_pc_o,
    output logic [rv_core_pkg::REG_ADDR_W-1:0]  wb_rd_o,
    output logic [rv_core_pkg::XLEN-1:0]        wb_data_o,
    output logic                                wb_we_o
);

    import rv_core_pkg::*;

    // APB between the memory stage and the data memory
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [XLEN-1:0]   paddr;
    logic [XLEN-1:0]   pwdata;
    logic [XLEN/8-1:0] pstrb;
    logic [XLEN-1:0]   prdata;
    logic              pready;

    // Memory stage to writeback
    logic              mem_valid;
    logic [XLEN-1:0]   mem_pc;
    logic [XLEN-1:0]   mem_inst;
    logic [XLEN-1:0]   mem_result;
    logic [XLEN-1:0]   mem_load_data;

    // Register file write port
    logic              rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]   rf_wdata;

    mem_access_unit mem_access_unit_i (
        .clk             (clk),
        .reset_i         (reset_i),
        .in_valid_i      (in_valid_i),
        .in_pc_i         (in_pc_i),
        .in_inst_i       (in_inst_i),
        .in_result_i     (in_result_i),
        .in_store_data_i (in_store_data_i),
        .in_ready_o      (in_ready_o),
        .psel_o          (psel),
        .penable_o       (penable),
        .pwrite_o        (pwrite),
        .paddr_o         (paddr),
        .pwdata_o        (pwdata),
        .pstrb_o         (pstrb),
        .prdata_i        (prdata),
        .pready_i        (pready),
        .mem_valid_o     (mem_valid),
        .mem_pc_o        (mem_pc),
        .mem_inst_o      (mem_inst),
        .mem_result_o    (mem_result),
        .mem_load_data_o (mem_load_data)
    );

    apb_data_mem apb_data_mem_i (
        .clk       (clk),
        .reset_i   (reset_i),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .pstrb_i   (pstrb),
        .prdata_o  (prdata),
        .pready_o  (pready)
    );

    write_back_unit write_back_unit_i (
        .clk             (clk),
        .reset_i         (reset_i),
        .mem_valid_i     (mem_valid),
        .mem_pc_i        (mem_pc),
        .mem_inst_i      (mem_inst),
        .mem_result_i    (mem_result),
        .mem_load_data_i (mem_load_data),
        .rf_we_o         (rf_we),
        .rf_waddr_o      (rf_waddr),
        .rf_wdata_o      (rf_wdata),
        .wb_valid_o      (wb_valid_o),
        .wb_pc_o         (wb_pc_o)
    );

    reg_file reg_file_i (
        .clk     (clk),
        .reset_i (reset_i),
        .we_i    (rf_we),
        .waddr_i (rf_waddr),
        .wdata_i (rf_wdata),
        .raddr_i (rs_addr_i),
        .rdata_o (rs_data_o)
    );

    // Retire report mirrors the register file write port
    assign wb_we_o   = rf_we;
    assign wb_rd_o   = rf_waddr;
    assign wb_data_o = rf_wdata;

endmodule

`default_nettype wire

/* verification/tb_lsu_wb_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_lsu_wb_top;

    import rv_core_pkg::*;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int STREAM_LEN     = 40;
    localparam int BYTE_AW        = DMEM_ADDR_W + 2;

    logic                  clk;
    logic                  reset_i;
    logic                  in_valid_i;
    logic [XLEN-1:0]       in_pc_i;
    logic [XLEN-1:0]       in_inst_i;
    logic [XLEN-1:0]       in_result_i;
    logic [XLEN-1:0]       in_store_data_i;
    logic                  in_ready_o;
    logic [REG_ADDR_W-1:0] rs_addr_i;
    logic [XLEN-1:0]       rs_data_o;
    logic                  wb_valid_o;
    logic [XLEN-1:0]       wb_pc_o;
    logic [REG_ADDR_W-1:0] wb_rd_o;
    logic [XLEN-1:0]       wb_data_o;
    logic                  wb_we_o;

    int              seed;
    int              value_errs;
    int              other_errs;
    int              cycle_cnt = 0;
    logic [XLEN-1:0] next_pc;

    // Expected retirements, oldest first
    logic [XLEN-1:0]       exp_pc_q[$];
    logic [REG_ADDR_W-1:0] exp_rd_q[$];
    logic [XLEN-1:0]       exp_data_q[$];
    logic                  exp_we_q[$];
    int                    exp_acc_q[$];
    int                    exp_lat_q[$];

    // Reference copies of the architectural state
    logic [XLEN-1:0] reg_model [0:2**REG_ADDR_W-1];
    logic [7:0]      shadow_mem [0:2**BYTE_AW-1];

    lsu_wb_top lsu_wb_top_i (
        .clk             (clk),
        .reset_i         (reset_i),
        .in_valid_i      (in_valid_i),
        .in_pc_i         (in_pc_i),
        .in_inst_i       (in_inst_i),
        .in_result_i     (in_result_i),
        .in_store_data_i (in_store_data_i),
        .in_ready_o      (in_ready_o),
        .rs_addr_i       (rs_addr_i),
        .rs_data_o       (rs_data_o),
        .wb_valid_o      (wb_valid_o),
        .wb_pc_o         (wb_pc_o),
        .wb_rd_o         (wb_rd_o),
        .wb_data_o       (wb_data_o),
        .wb_we_o         (wb_we_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic word_compare(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic index_compare(input string name, input logic [REG_ADDR_W-1:0] got,
                                 input logic [REG_ADDR_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic bit_compare(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    function automatic logic [XLEN-1:0] encode_inst(input logic [6:0] opcode,
                                                    input logic [REG_ADDR_W-1:0] rd,
                                                    input logic [2:0] f3);
        return {17'd0, f3, rd, opcode};
    endfunction

    // Load value built byte by byte from the reference memory
    function automatic logic [XLEN-1:0] expect_load(input logic [XLEN-1:0] addr,
                                                    input logic [2:0] f3);
        logic [BYTE_AW-1:0] a;
        logic [7:0]         b0;
        logic [7:0]         b1;
        logic [XLEN-1:0]    val;
        a  = addr[BYTE_AW-1:0];
        b0 = shadow_mem[a];
        b1 = shadow_mem[a + BYTE_AW'(1)];
        case (f3)
            F3_LB:   val = {{24{b0[7]}}, b0};
            F3_LBU:  val = {24'd0, b0};
            F3_LH:   val = {{16{b1[7]}}, b1, b0};
            F3_LHU:  val = {16'd0, b1, b0};
            default: val = {shadow_mem[a + BYTE_AW'(3)], shadow_mem[a + BYTE_AW'(2)], b1, b0};
        endcase
        return val;
    endfunction

    task automatic shadow_store(input logic [XLEN-1:0] addr, input logic [2:0] f3,
                                input logic [XLEN-1:0] data);
        int nbytes;
        nbytes = (f3 == F3_SB) ? 1 : ((f3 == F3_SH) ? 2 : 4);
        for (int i = 0; i < nbytes; i++) begin
            shadow_mem[addr[BYTE_AW-1:0] + BYTE_AW'(i)] = data[8*i +: 8];
        end
    endtask

    // Hands one instruction over and records what it should retire with
    task automatic issue_inst(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] inst,
                              input logic [XLEN-1:0] result, input logic [XLEN-1:0] sdata);
        int                    waited;
        logic [6:0]            op;
        logic [REG_ADDR_W-1:0] rd;
        logic [2:0]            f3;
        logic                  writes;
        logic [XLEN-1:0]       data;
        waited = 0;
        op     = inst[6:0];
        rd     = inst[11:7];
        f3     = inst[14:12];
        writes = 1'b0;
        data   = '0;
        while (!in_ready_o && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!in_ready_o) begin
            $display("Timeout: in_ready_o stayed low, instruction at pc %h not issued", pc);
            other_errs++;
        end else begin
            in_valid_i      = 1'b1;
            in_pc_i         = pc;
            in_inst_i       = inst;
            in_result_i     = result;
            in_store_data_i = sdata;
            @(posedge clk);
            #1;
            in_valid_i = 1'b0;
            case (op)
                OPCODE_JAL, OPCODE_JALR: begin
                    writes = 1'b1;
                    data   = pc + 32'd4;
                end
                OPCODE_LOAD: begin
                    writes = 1'b1;
                    data   = expect_load(result, f3);
                end
                OPCODE_LUI, OPCODE_AUIPC, OPCODE_OP, OPCODE_OP_IMM: begin
                    writes = 1'b1;
                    data   = result;
                end
                OPCODE_STORE: shadow_store(result, f3, sdata);
                default: writes = 1'b0;
            endcase
            exp_pc_q.push_back(pc);
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(data);
            exp_we_q.push_back(writes && (rd != '0));
            // Acceptance cycle is the one that ended on the last edge
            exp_acc_q.push_back(cycle_cnt - 1);
            exp_lat_q.push_back((op == OPCODE_LOAD || op == OPCODE_STORE) ? 5 : 2);
            if (writes && (rd != '0)) begin
                reg_model[rd] = data;
            end
        end
    endtask

    task automatic issue_next(input logic [XLEN-1:0] inst, input logic [XLEN-1:0] result,
                              input logic [XLEN-1:0] sdata);
        issue_inst(next_pc, inst, result, sdata);
        next_pc = next_pc + 32'd4;
    endtask

    task automatic retire_check();
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
        logic                  we;
        int                    acc;
        int                    lat;
        if (exp_pc_q.size() == 0) begin
            $display("Instruction at pc %h retired with none outstanding", wb_pc_o);
            other_errs++;
        end else begin
            pc   = exp_pc_q.pop_front();
            rd   = exp_rd_q.pop_front();
            data = exp_data_q.pop_front();
            we   = exp_we_q.pop_front();
            acc  = exp_acc_q.pop_front();
            lat  = exp_lat_q.pop_front();
            word_compare("wb_pc_o", wb_pc_o, pc);
            bit_compare("wb_we_o", wb_we_o, we);
            if (we) begin
                index_compare("wb_rd_o", wb_rd_o, rd);
                word_compare("wb_data_o", wb_data_o, data);
            end
            if (cycle_cnt - acc != lat) begin
                $display("Instruction at pc %h retired %0d cycles after acceptance, not %0d",
                         pc, cycle_cnt - acc, lat);
                other_errs++;
            end
        end
    endtask

    // Retire monitor, sampled just after each edge
    always @(posedge clk) begin
        #1;
        if (!reset_i && wb_valid_o) begin
            retire_check();
        end
    end

    task automatic wait_retired();
        int waited;
        waited = 0;
        while (exp_pc_q.size() != 0 && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_pc_q.size() != 0) begin
            $display("Timeout: %0d instructions never retired", exp_pc_q.size());
            other_errs++;
            exp_pc_q.delete();
            exp_rd_q.delete();
            exp_data_q.delete();
            exp_we_q.delete();
            exp_acc_q.delete();
            exp_lat_q.delete();
        end
        // Last write lands in the register file on the next edge
        @(posedge clk);
        #1;
    endtask

    task automatic reg_readback(input logic [REG_ADDR_W-1:0] idx);
        rs_addr_i = idx;
        @(negedge clk);
        word_compare($sformatf("rs_data_o (x%0d)", idx), rs_data_o, reg_model[idx]);
        @(posedge clk);
        #1;
    endtask

    task automatic reset_state_test();
        bit_compare("in_ready_o", in_ready_o, 1'b1);
        bit_compare("wb_valid_o", wb_valid_o, 1'b0);
        for (int r = 0; r < 32; r++) begin
            reg_readback(5'(r));
        end
    endtask

    task automatic alu_write_test();
        next_pc = 32'h0000_0100;
        issue_next(encode_inst(OPCODE_OP, 5'd1, 3'b000), 32'h1234_5678, '0);
        issue_next(encode_inst(OPCODE_OP_IMM, 5'd2, 3'b111), 32'h8000_0001, '0);
        issue_next(encode_inst(OPCODE_LUI, 5'd3, 3'b000), 32'habcd_e000, '0);
        issue_next(encode_inst(OPCODE_AUIPC, 5'd31, 3'b000), 32'h0001_010c, '0);
        // Back to back rewrite of x1
        issue_next(encode_inst(OPCODE_OP, 5'd1, 3'b001), 32'hffff_fffe, '0);
        wait_retired();
        reg_readback(5'd1);
        reg_readback(5'd2);
        reg_readback(5'd3);
        reg_readback(5'd31);
    endtask

    task automatic jump_link_test();
        issue_inst(32'h0000_0200, encode_inst(OPCODE_JAL, 5'd5, 3'b000), 32'h0000_0400, '0);
        issue_inst(32'h7fff_fffc, encode_inst(OPCODE_JALR, 5'd6, 3'b000), 32'h0000_0010, '0);
        wait_retired();
        reg_readback(5'd5);
        reg_readback(5'd6);
    endtask

    task automatic load_store_test();
        next_pc = 32'h0000_0300;
        issue_next(encode_inst(OPCODE_STORE, 5'd0, F3_SW), 32'h40, 32'h8bad_f00d);
        issue_next(encode_inst(OPCODE_LOAD, 5'd10, F3_LW), 32'h40, '0);
        for (int off = 0; off < 4; off += 2) begin
            issue_next(encode_inst(OPCODE_LOAD, 5'd11, F3_LH), 32'h40 + 32'(off), '0);
            issue_next(encode_inst(OPCODE_LOAD, 5'd12, F3_LHU), 32'h40 + 32'(off), '0);
        end
        for (int off = 0; off < 4; off++) begin
            issue_next(encode_inst(OPCODE_LOAD, 5'd13, F3_LB), 32'h40 + 32'(off), '0);
            issue_next(encode_inst(OPCODE_LOAD, 5'd14, F3_LBU), 32'h40 + 32'(off), '0);
        end
        // Sub-word stores, upper data bits must not leak into other lanes
        issue_next(encode_inst(OPCODE_STORE, 5'd0, F3_SW), 32'h44, 32'h0102_0304);
        issue_next(encode_inst(OPCODE_STORE, 5'd0, F3_SB), 32'h41, 32'ha5a5_a55a);
        issue_next(encode_inst(OPCODE_STORE, 5'd0, F3_SH), 32'h46, 32'hdead_1234);
        issue_next(encode_inst(OPCODE_LOAD, 5'd15, F3_LW), 32'h40, '0);
        issue_next(encode_inst(OPCODE_LOAD, 5'd16, F3_LW), 32'h44, '0);
        wait_retired();
        for (int r = 10; r < 17; r++) begin
            reg_readback(5'(r));
        end
    endtask

    task automatic no_write_test();
        next_pc = 32'h0000_0500;
        issue_next(encode_inst(OPCODE_OP, 5'd7, 3'b000), 32'hcafe_0001, '0);
        issue_next(encode_inst(OPCODE_BRANCH, 5'd7, 3'b001), 32'h0000_0001, '0);
        issue_next(encode_inst(OPCODE_STORE, 5'd7, F3_SW), 32'h80, 32'h7777_7777);
        issue_next(encode_inst(OPCODE_SYSTEM, 5'd7, 3'b000), 32'h0000_0005, '0);
        issue_next(encode_inst(OPCODE_OP, 5'd0, 3'b000), 32'hdead_beef, '0);
        issue_next(encode_inst(OPCODE_JAL, 5'd0, 3'b000), '0, '0);
        issue_next(encode_inst(OPCODE_LOAD, 5'd0, F3_LW), 32'h80, '0);
        wait_retired();
        reg_readback(5'd7);
        reg_readback(5'd0);
    endtask

    task automatic mixed_stream_test();
        int                    gap;
        int                    kind;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       addr;
        next_pc = 32'h0000_1000;
        // Known contents for the loads that follow
        for (int w = 0; w < 16; w++) begin
            issue_next(encode_inst(OPCODE_STORE, 5'd0, F3_SW), 32'h100 + 32'(4*w), $random(seed));
        end
        for (int n = 0; n < STREAM_LEN; n++) begin
            gap  = $unsigned($random(seed)) % 4;
            kind = $unsigned($random(seed)) % 6;
            rd   = 5'($unsigned($random(seed)));
            addr = 32'h100 + ($unsigned($random(seed)) & 32'h3f);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            case (kind)
                0: issue_next(encode_inst(OPCODE_OP, rd, 3'b000), $random(seed), '0);
                1: issue_next(encode_inst(OPCODE_LUI, rd, 3'b000), $random(seed), '0);
                2: issue_next(encode_inst(OPCODE_JAL, rd, 3'b000), '0, '0);
                3: issue_next(encode_inst(OPCODE_LOAD, rd, F3_LBU), addr, '0);
                4: issue_next(encode_inst(OPCODE_STORE, rd, F3_SB), addr, $random(seed));
                default: issue_next(encode_inst(OPCODE_BRANCH, rd, 3'b000), '0, '0);
            endcase
        end
        wait_retired();
        for (int r = 1; r < 32; r++) begin
            reg_readback(5'(r));
        end
    endtask

    initial begin
        seed            = 32'hc137fafd;
        value_errs      = 0;
        other_errs      = 0;
        next_pc         = '0;
        reset_i         = 1'b1;
        in_valid_i      = 1'b0;
        in_pc_i         = '0;
        in_inst_i       = '0;
        in_result_i     = '0;
        in_store_data_i = '0;
        rs_addr_i       = '0;
        for (int r = 0; r < 32; r++) begin
            reg_model[r] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        reset_i = 1'b0;

        reset_state_test();
        alu_write_test();
        jump_link_test();
        load_store_test();
        no_write_test();
        mixed_stream_test();

        $display("Errors: %0d value mismatches, %0d timeouts or other failures",
                 value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
src/rv_core_pkg.sv
src/mem_access_unit.sv
src/apb_data_mem.sv
src/write_back_unit.sv
src/reg_file.sv
src/lsu_wb_top.sv
verification/tb_lsu_wb_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the lsu_wb_top testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing -Wno-fatal \
    -f project.f \
    --top-module tb_lsu_wb_top \
    -Mdir "$BUILD_DIR"

"$BUILD_DIR/Vtb_lsu_wb_top" > "$LOG" 2>&1
cat "$LOG"

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    echo "Simulation reported failure, see $LOG"
    exit 1
fi
